// File: gdc_out_settings.svh
`ifndef GDC_OUT_SETTINGS_SVH
`define GDC_OUT_SETTINGS_SVH

////////////////////
// pixel and bank geometry
////////////////////

// bits per pixel
`define GDC_PIXEL_W 16

// coordinates per block, also the depth of one bank
`define GDC_COORD_NUM 16

// blocks in one frame
`define GDC_BLOCK_NUM 4

////////////////////
// controller timing
////////////////////

// power-up wait before a start is honoured
`define GDC_INIT_TIME 50

// settle cycles before a bank goes back to the writer
`define GDC_RD_WAIT_NUM 2

// coordinate accept to pixel out
`define GDC_FETCH_LAT 2

`endif

// File: gdc_pixel_pkg.sv
`include "gdc_out_settings.svh"

package gdc_pixel_pkg;

    // address bits inside one bank
    localparam int BANK_ADDR_W = $clog2(`GDC_COORD_NUM);

    // one corrected pixel
    typedef logic [`GDC_PIXEL_W-1:0] pixel_t;

    // one word as held in bank storage
    typedef logic [`GDC_PIXEL_W-1:0] data_word_t;

    // pixel address inside a bank, also the map coordinate
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

// File: gdc_ctrl_pkg.sv
package gdc_ctrl_pkg;

    // bank select, none means no bank owned
    typedef enum logic [1:0] {
        RAM_NONE = 2'd0,
        RAM_A    = 2'd1,
        RAM_B    = 2'd2
    } ram_id_t;

    // output controller states
    // init is all zero, the rest one-hot
    typedef enum logic [4:0] {
        INIT          = 5'b00000,
        IDLE          = 5'b00001,
        RD_RAM_A      = 5'b00010,
        RD_RAM_B      = 5'b00100,
        RD_RAM_A_WAIT = 5'b01000,
        RD_RAM_B_WAIT = 5'b10000
    } out_state_t;

endpackage

// File: signal_delay.sv
`include "gdc_out_settings.svh"

module signal_delay #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rstn,
    input  T     i_d,
    output T     o_q
);

    localparam int DEPTH = `GDC_FETCH_LAT;

    T pipe [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= T'(0);
            end
        end else begin
            pipe[0] <= i_d;
            // shift toward the output
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign o_q = pipe[DEPTH-1];

endmodule

// File: pixel_bank_writer.sv
`include "gdc_out_settings.svh"

module pixel_bank_writer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_soft_rstn,
    input  logic                      i_gdc_start,
    input  logic                      i_src_valid,
    input  gdc_pixel_pkg::pixel_t     i_src_pixel,
    input  gdc_ctrl_pkg::ram_id_t     i_rd_ram_id,
    output gdc_ctrl_pkg::ram_id_t     o_wr_ram_id,
    output logic                      o_wr_en,
    output gdc_pixel_pkg::bank_addr_t o_wr_addr,
    output gdc_pixel_pkg::pixel_t     o_wr_pixel,
    output logic                      o_ram_ready
);
    import gdc_pixel_pkg::*;
    import gdc_ctrl_pkg::*;

    localparam int               BLK_W     = $clog2(`GDC_BLOCK_NUM) + 1;
    localparam logic [BLK_W-1:0] BLK_ALL   = BLK_W'(`GDC_BLOCK_NUM);
    localparam bank_addr_t       ADDR_LAST = bank_addr_t'(`GDC_COORD_NUM - 1);

    logic             start_d;
    logic             start_pos;
    logic             full_a;
    logic             full_b;
    logic             free_a;
    logic             free_b;
    logic             fill_free;
    logic             blk_done;
    ram_id_t          fill_bank;
    ram_id_t          rd_prev;
    bank_addr_t       wr_addr;
    logic [BLK_W-1:0] blk_cnt;

    assign start_pos = i_gdc_start & ~start_d;

    // reader just moved off a bank
    assign free_a = (rd_prev == RAM_A) && (i_rd_ram_id != RAM_A);
    assign free_b = (rd_prev == RAM_B) && (i_rd_ram_id != RAM_B);

    assign fill_free = (fill_bank == RAM_A) ? !full_a : !full_b;

    // blk_cnt at BLK_ALL also covers the idle state before any start
    assign o_wr_ram_id = (blk_cnt != BLK_ALL && fill_free) ? fill_bank : RAM_NONE;
    assign o_wr_en     = i_src_valid && (o_wr_ram_id != RAM_NONE);
    assign o_wr_addr   = wr_addr;
    assign o_wr_pixel  = i_src_pixel;
    assign blk_done    = o_wr_en && (wr_addr == ADDR_LAST);

    assign o_ram_ready = (full_a && i_rd_ram_id != RAM_A) ||
                         (full_b && i_rd_ram_id != RAM_B);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_d   <= 1'b0;
            rd_prev   <= RAM_NONE;
            full_a    <= 1'b0;
            full_b    <= 1'b0;
            fill_bank <= RAM_A;
            wr_addr   <= '0;
            blk_cnt   <= BLK_ALL;
        end else begin
            start_d <= i_gdc_start;
            rd_prev <= i_rd_ram_id;
            if (!i_soft_rstn || start_pos) begin
                full_a    <= 1'b0;
                full_b    <= 1'b0;
                fill_bank <= RAM_A;
                wr_addr   <= '0;
                // a start opens a new frame, soft reset closes it
                blk_cnt   <= i_soft_rstn ? '0 : BLK_ALL;
            end else begin
                if (free_a) begin
                    full_a <= 1'b0;
                end
                if (free_b) begin
                    full_b <= 1'b0;
                end
                if (o_wr_en) begin
                    wr_addr <= blk_done ? '0 : wr_addr + 1'b1;
                end
                if (blk_done) begin
                    if (fill_bank == RAM_A) begin
                        full_a <= 1'b1;
                    end else begin
                        full_b <= 1'b1;
                    end
                    fill_bank <= (fill_bank == RAM_A) ? RAM_B : RAM_A;
                    blk_cnt   <= blk_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: pingpong_pixel_ram.sv
`include "gdc_out_settings.svh"

module pingpong_pixel_ram (
    input  logic                      clk,
    input  logic                      i_wr_en,
    input  gdc_ctrl_pkg::ram_id_t     i_wr_bank,
    input  gdc_pixel_pkg::bank_addr_t i_wr_addr,
    input  gdc_pixel_pkg::pixel_t     i_wr_pixel,
    input  gdc_ctrl_pkg::ram_id_t     i_rd_bank,
    input  gdc_pixel_pkg::bank_addr_t i_rd_addr,
    output gdc_pixel_pkg::pixel_t     o_rd_pixel
);
    import gdc_pixel_pkg::*;
    import gdc_ctrl_pkg::*;

    localparam int DEPTH = `GDC_COORD_NUM;

    data_word_t mem_a [DEPTH];
    data_word_t mem_b [DEPTH];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_wr_en && i_wr_bank == RAM_A) begin
            mem_a[i_wr_addr] <= i_wr_pixel;
        end
        if (i_wr_en && i_wr_bank == RAM_B) begin
            mem_b[i_wr_addr] <= i_wr_pixel;
        end
    end

    ////////////////////
    // registered read port
    ////////////////////

    // holds last word when no bank is selected
    always_ff @(posedge clk) begin
        case (i_rd_bank)
            RAM_A:   o_rd_pixel <= mem_a[i_rd_addr];
            RAM_B:   o_rd_pixel <= mem_b[i_rd_addr];
            default: o_rd_pixel <= o_rd_pixel;
        endcase
    end

endmodule

// File: pixel_fetch.sv
module pixel_fetch (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_rd_en,
    input  gdc_pixel_pkg::bank_addr_t i_map_coord,
    input  gdc_ctrl_pkg::ram_id_t     i_rd_ram_id,
    output gdc_ctrl_pkg::ram_id_t     o_rd_bank,
    output gdc_pixel_pkg::bank_addr_t o_rd_addr,
    input  gdc_pixel_pkg::pixel_t     i_rd_pixel,
    output logic                      o_pix_valid,
    output gdc_pixel_pkg::pixel_t     o_pix_data
);
    import gdc_ctrl_pkg::*;

    logic    vld_q;
    ram_id_t bank_q;

    // request bank, idle reads select no bank
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_rd_bank <= RAM_NONE;
        end else begin
            o_rd_bank <= i_rd_en ? i_rd_ram_id : RAM_NONE;
        end
    end

    // request address
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_addr <= i_map_coord;
        end
    end

    ////////////////////
    // in-flight tracking
    ////////////////////

    // one entry per accepted coordinate, lined up with the ram output
    signal_delay #(
        .T (logic)
    ) u_vld_dly (
        .clk  (clk),
        .rstn (rstn),
        .i_d  (i_rd_en),
        .o_q  (vld_q)
    );

    signal_delay #(
        .T (ram_id_t)
    ) u_bank_dly (
        .clk  (clk),
        .rstn (rstn),
        .i_d  (i_rd_ram_id),
        .o_q  (bank_q)
    );

    // a read issued with no bank owned carries no pixel
    assign o_pix_valid = vld_q && (bank_q != RAM_NONE);
    assign o_pix_data  = o_pix_valid ? i_rd_pixel : '0;

endmodule

// File: pixel_out_ctrl.sv
`include "gdc_out_settings.svh"

module pixel_out_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_soft_rstn,
    input  logic                  i_gdc_start,
    input  logic                  i_pix_ready,
    input  logic                  i_map_valid,
    input  logic                  i_ram_ready,
    input  gdc_ctrl_pkg::ram_id_t i_wr_ram_id,
    output logic                  o_map_ready,
    output logic                  o_rd_en,
    output gdc_ctrl_pkg::ram_id_t o_rd_ram_id,
    output logic                  o_frame_finish
);
    import gdc_ctrl_pkg::*;

    localparam int INIT_W  = $clog2(`GDC_INIT_TIME);
    localparam int COORD_W = $clog2(`GDC_COORD_NUM) + 1;
    localparam int BLK_W   = $clog2(`GDC_BLOCK_NUM) + 1;
    localparam int WAIT_W  = $clog2(`GDC_RD_WAIT_NUM) + 1;

    localparam logic [INIT_W-1:0]  INIT_LAST  = INIT_W'(`GDC_INIT_TIME - 1);
    localparam logic [COORD_W-1:0] COORD_LAST = COORD_W'(`GDC_COORD_NUM - 1);
    localparam logic [COORD_W-1:0] COORD_ALL  = COORD_W'(`GDC_COORD_NUM);
    localparam logic [BLK_W-1:0]   BLK_ALL    = BLK_W'(`GDC_BLOCK_NUM);
    localparam logic [WAIT_W-1:0]  WAIT_DONE  = WAIT_W'(`GDC_RD_WAIT_NUM);

    out_state_t         c_state;
    out_state_t         n_state;
    logic [INIT_W-1:0]  cnt_init;
    logic [COORD_W-1:0] cnt_coord;
    logic [COORD_W-1:0] cnt_coord_1;
    logic [BLK_W-1:0]   cnt_block;
    logic [WAIT_W-1:0]  cnt_wait;
    logic               start_d0;
    logic               start_d1;
    logic               start_pos;
    logic               init_done;
    logic               accept;
    logic               block_end;
    logic               handover;

    assign start_pos = start_d0 & ~start_d1;
    assign init_done = (cnt_init == INIT_LAST);
    assign accept    = i_map_valid & o_map_ready;
    assign o_rd_en   = accept;
    assign block_end = accept && (cnt_coord == COORD_LAST);

    // whole block taken, settled, and the writer has the other bank full
    assign handover = (cnt_coord_1 == COORD_ALL) && (cnt_wait == WAIT_DONE) &&
                      (i_wr_ram_id == RAM_NONE);

    ////////////////////
    // start and counters
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
        end else begin
            start_d0 <= i_gdc_start;
            start_d1 <= start_d0;
        end
    end

    // power-up wait, restarted by soft reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_init <= '0;
        end else if (!i_soft_rstn) begin
            cnt_init <= '0;
        end else if (!init_done) begin
            cnt_init <= cnt_init + 1'b1;
        end
    end

    // cnt_coord stops at the last index, cnt_coord_1 runs one past it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_coord   <= '0;
            cnt_coord_1 <= '0;
        end else if (start_pos || o_rd_ram_id == RAM_NONE) begin
            cnt_coord   <= '0;
            cnt_coord_1 <= '0;
        end else if (accept) begin
            if (cnt_coord != COORD_LAST) begin
                cnt_coord <= cnt_coord + 1'b1;
            end
            cnt_coord_1 <= cnt_coord_1 + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_block      <= '0;
            o_frame_finish <= 1'b0;
        end else if (start_pos) begin
            cnt_block      <= '0;
            o_frame_finish <= 1'b0;
        end else begin
            if (block_end) begin
                cnt_block <= cnt_block + 1'b1;
            end
            if (cnt_block == BLK_ALL) begin
                o_frame_finish <= 1'b1;
            end
        end
    end

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            c_state <= INIT;
        end else begin
            c_state <= n_state;
        end
    end

    always_comb begin
        n_state = c_state;
        if (!i_soft_rstn) begin
            n_state = INIT;
        end else begin
            case (c_state)
                INIT:          if (init_done && start_pos) n_state = IDLE;
                IDLE:          if (i_ram_ready) n_state = RD_RAM_A;
                RD_RAM_A:      if (block_end) n_state = RD_RAM_A_WAIT;
                RD_RAM_B:      if (block_end) n_state = RD_RAM_B_WAIT;
                RD_RAM_A_WAIT: begin
                    if (cnt_block == BLK_ALL) n_state = INIT;
                    else if (o_rd_ram_id == RAM_NONE) n_state = RD_RAM_B;
                end
                RD_RAM_B_WAIT: begin
                    if (cnt_block == BLK_ALL) n_state = INIT;
                    else if (o_rd_ram_id == RAM_NONE) n_state = RD_RAM_A;
                end
                default:       n_state = INIT;
            endcase
        end
    end

    // outputs follow the next state
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt_wait    <= '0;
            o_rd_ram_id <= RAM_NONE;
            o_map_ready <= 1'b0;
        end else begin
            case (n_state)
                RD_RAM_A, RD_RAM_B: begin
                    cnt_wait    <= '0;
                    o_rd_ram_id <= (n_state == RD_RAM_A) ? RAM_A : RAM_B;
                    o_map_ready <= i_pix_ready;
                end
                RD_RAM_A_WAIT, RD_RAM_B_WAIT: begin
                    if (cnt_wait != WAIT_DONE) begin
                        cnt_wait <= cnt_wait + 1'b1;
                    end
                    if (handover) begin
                        o_rd_ram_id <= RAM_NONE;
                    end else begin
                        o_rd_ram_id <= (n_state == RD_RAM_A_WAIT) ? RAM_A : RAM_B;
                    end
                    o_map_ready <= 1'b0;
                end
                default: begin
                    cnt_wait    <= '0;
                    o_rd_ram_id <= RAM_NONE;
                    o_map_ready <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: gdc_out_top.sv
module gdc_out_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_soft_rstn,
    input  logic                      i_gdc_start,
    input  logic                      i_src_valid,
    input  gdc_pixel_pkg::pixel_t     i_src_pixel,
    input  logic                      i_map_valid,
    input  gdc_pixel_pkg::bank_addr_t i_map_coord,
    input  logic                      i_pix_ready,
    output logic                      o_map_ready,
    output logic                      o_pix_valid,
    output gdc_pixel_pkg::pixel_t     o_pix_data,
    output gdc_ctrl_pkg::ram_id_t     o_rd_ram_id,
    output logic                      o_frame_finish
);
    import gdc_pixel_pkg::*;
    import gdc_ctrl_pkg::*;

    ram_id_t    wr_ram_id;
    ram_id_t    rd_ram_id;
    ram_id_t    rd_bank;
    logic       ram_ready;
    logic       rd_en;
    logic       wr_en;
    bank_addr_t wr_addr;
    bank_addr_t rd_addr;
    pixel_t     wr_pixel;
    pixel_t     rd_pixel;

    assign o_rd_ram_id = rd_ram_id;

    ////////////////////
    // write side
    ////////////////////

    pixel_bank_writer u_writer (
        .clk         (clk),
        .rstn        (rstn),
        .i_soft_rstn (i_soft_rstn),
        .i_gdc_start (i_gdc_start),
        .i_src_valid (i_src_valid),
        .i_src_pixel (i_src_pixel),
        .i_rd_ram_id (rd_ram_id),
        .o_wr_ram_id (wr_ram_id),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_pixel  (wr_pixel),
        .o_ram_ready (ram_ready)
    );

    pingpong_pixel_ram u_ram (
        .clk        (clk),
        .i_wr_en    (wr_en),
        .i_wr_bank  (wr_ram_id),
        .i_wr_addr  (wr_addr),
        .i_wr_pixel (wr_pixel),
        .i_rd_bank  (rd_bank),
        .i_rd_addr  (rd_addr),
        .o_rd_pixel (rd_pixel)
    );

    ////////////////////
    // read side
    ////////////////////

    pixel_fetch u_fetch (
        .clk         (clk),
        .rstn        (rstn),
        .i_rd_en     (rd_en),
        .i_map_coord (i_map_coord),
        .i_rd_ram_id (rd_ram_id),
        .o_rd_bank   (rd_bank),
        .o_rd_addr   (rd_addr),
        .i_rd_pixel  (rd_pixel),
        .o_pix_valid (o_pix_valid),
        .o_pix_data  (o_pix_data)
    );

    pixel_out_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_soft_rstn    (i_soft_rstn),
        .i_gdc_start    (i_gdc_start),
        .i_pix_ready    (i_pix_ready),
        .i_map_valid    (i_map_valid),
        .i_ram_ready    (ram_ready),
        .i_wr_ram_id    (wr_ram_id),
        .o_map_ready    (o_map_ready),
        .o_rd_en        (rd_en),
        .o_rd_ram_id    (rd_ram_id),
        .o_frame_finish (o_frame_finish)
    );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for three rising edges, released away from the edge
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// File: tb_gdc_out.sv
`include "gdc_out_settings.svh"

module tb_gdc_out;
    timeunit 1ns;
    timeprecision 100ps;

    import gdc_pixel_pkg::*;
    import gdc_ctrl_pkg::*;

    localparam int COORD     = `GDC_COORD_NUM;
    localparam int FRAME_PIX = `GDC_BLOCK_NUM * `GDC_COORD_NUM;
    // slowest frame stays under 18 cycles per pixel plus block waits
    localparam int FRAME_CYC   = FRAME_PIX * 18 + 48;
    // three frames and room for eight init waits
    localparam int CYCLE_LIMIT = 3 * FRAME_CYC + 8 * `GDC_INIT_TIME;
    localparam int GATE_CYC    = `GDC_INIT_TIME + 20;

    logic       clk;
    logic       rstn;
    logic       i_soft_rstn;
    logic       i_gdc_start;
    logic       i_src_valid;
    pixel_t     i_src_pixel;
    logic       i_map_valid;
    bank_addr_t i_map_coord;
    logic       i_pix_ready;
    logic       o_map_ready;
    logic       o_pix_valid;
    pixel_t     o_pix_data;
    ram_id_t    o_rd_ram_id;
    logic       o_frame_finish;

    int      seed;
    int      cycle_cnt;
    int      err_cnt;
    int      test_err0;
    int      tests_run;
    int      tests_ok;
    string   cur_test;
    logic    src_on;
    logic    map_on;
    int      src_rate;
    int      ready_rate;
    int      src_cnt;
    int      acc_cnt;
    int      pix_cnt;
    int      ready_err;
    int      gate_err;
    ram_id_t last_rd_id;
    pixel_t  src_model [FRAME_PIX];
    pixel_t  exp_q [$];
    ram_id_t bank_seq [$];

    tb_clock_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    gdc_out_top gdc_out_top_inst (
        .clk            (clk),
        .rstn           (rstn),
        .i_soft_rstn    (i_soft_rstn),
        .i_gdc_start    (i_gdc_start),
        .i_src_valid    (i_src_valid),
        .i_src_pixel    (i_src_pixel),
        .i_map_valid    (i_map_valid),
        .i_map_coord    (i_map_coord),
        .i_pix_ready    (i_pix_ready),
        .o_map_ready    (o_map_ready),
        .o_pix_valid    (o_pix_valid),
        .o_pix_data     (o_pix_data),
        .o_rd_ram_id    (o_rd_ram_id),
        .o_frame_finish (o_frame_finish)
    );

    function automatic int roll(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            err_cnt++;
        end
    endtask

    ////////////////////
    // downstream and bank monitor
    ////////////////////

    task automatic observe_outputs();
        pixel_t exp_pix;
        if (o_pix_valid) begin
            pix_cnt++;
            if (exp_q.size() > 0) begin
                exp_pix = exp_q.pop_front();
                compare_value("pixel", 32'(exp_pix), 32'(o_pix_data));
            end
        end
        // i_pix_ready still holds the value of the last rising edge
        if (o_map_ready && !i_pix_ready) begin
            ready_err++;
        end
        if (o_map_ready || o_rd_ram_id != RAM_NONE) begin
            gate_err++;
        end
        if (o_rd_ram_id != last_rd_id) begin
            bank_seq.push_back(o_rd_ram_id);
            last_rd_id = o_rd_ram_id;
        end
    endtask

    ////////////////////
    // source and map controller
    ////////////////////

    task automatic drive_inputs();
        int idx;
        i_src_valid = 1'b0;
        // send only while the writer owns a bank
        if (src_on && gdc_out_top_inst.wr_ram_id != RAM_NONE && roll(8) < src_rate) begin
            i_src_valid = 1'b1;
            i_src_pixel = pixel_t'($random(seed));
            if (src_cnt < FRAME_PIX) begin
                src_model[src_cnt] = i_src_pixel;
            end
            src_cnt++;
        end
        i_pix_ready = (roll(8) < ready_rate);
        i_map_valid = 1'b0;
        if (map_on && roll(2) == 0) begin
            i_map_valid = 1'b1;
            i_map_coord = bank_addr_t'(roll(COORD));
            // o_map_ready is settled until the next rising edge
            if (o_map_ready) begin
                idx = ((acc_cnt / COORD) * COORD + int'(i_map_coord)) % FRAME_PIX;
                exp_q.push_back(src_model[idx]);
                acc_cnt++;
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        observe_outputs();
        drive_inputs();
    endtask

    task automatic pulse_start();
        src_cnt    = 0;
        acc_cnt    = 0;
        pix_cnt    = 0;
        ready_err  = 0;
        last_rd_id = o_rd_ram_id;
        exp_q.delete();
        bank_seq.delete();
        i_gdc_start = 1'b1;
        repeat (2) step_cycle();
        i_gdc_start = 1'b0;
    endtask

    task automatic finish_frame();
        while (!o_frame_finish) begin
            step_cycle();
        end
        // last reads still in the fetch pipeline
        repeat (4) step_cycle();
        compare_value("accepted coordinates", FRAME_PIX, acc_cnt);
        compare_value("delivered pixels", acc_cnt, pix_cnt);
    endtask

    // early start edge, then nothing may be read for a while
    task automatic watch_gate();
        repeat (5) step_cycle();
        pulse_start();
        gate_err = 0;
        repeat (GATE_CYC) step_cycle();
        compare_value("cycles with ready or bank", 0, gate_err);
        compare_value("accepted coordinates", 0, acc_cnt);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_err0) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, err_cnt - test_err0);
        end
    endtask

    ////////////////////
    // run limit
    ////////////////////

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles before all tests ended", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        ram_id_t exp_id;
        seed        = 88230;
        err_cnt     = 0;
        tests_run   = 0;
        tests_ok    = 0;
        cur_test    = "reset";
        src_on      = 1'b0;
        map_on      = 1'b0;
        src_rate    = 0;
        ready_rate  = 8;
        last_rd_id  = RAM_NONE;
        i_soft_rstn = 1'b1;
        i_gdc_start = 1'b0;
        i_src_valid = 1'b0;
        i_src_pixel = '0;
        i_map_valid = 1'b0;
        i_map_coord = '0;
        i_pix_ready = 1'b0;
        wait (rstn === 1'b1);

        begin_test("init_gate");
        src_on   = 1'b1;
        map_on   = 1'b1;
        src_rate = 4;
        watch_gate();
        end_test();

        // slow source, so reads must wait for full banks
        begin_test("frame_data");
        src_rate   = 2;
        ready_rate = 8;
        pulse_start();
        finish_frame();
        end_test();

        begin_test("ping_pong");
        compare_value("bank changes", 2 * `GDC_BLOCK_NUM, bank_seq.size());
        for (int k = 0; k < bank_seq.size(); k++) begin
            if (k % 2 == 1) begin
                exp_id = RAM_NONE;
            end else begin
                exp_id = ((k / 2) % 2 == 0) ? RAM_A : RAM_B;
            end
            compare_value("bank order", 32'(exp_id), 32'(bank_seq[k]));
        end
        end_test();

        begin_test("back_pressure");
        src_rate   = 6;
        ready_rate = 4;
        pulse_start();
        finish_frame();
        compare_value("ready without downstream ready", 0, ready_err);
        end_test();

        begin_test("finish");
        compare_value("finish flag", 1, 32'(o_frame_finish));
        compare_value("map ready", 0, 32'(o_map_ready));
        compare_value("read bank", 32'(RAM_NONE), 32'(o_rd_ram_id));
        src_rate   = 4;
        ready_rate = 6;
        pulse_start();
        compare_value("finish after start", 0, 32'(o_frame_finish));
        finish_frame();
        compare_value("finish flag again", 1, 32'(o_frame_finish));
        end_test();

        begin_test("soft_reset");
        i_soft_rstn = 1'b0;
        repeat (2) step_cycle();
        i_soft_rstn = 1'b1;
        watch_gate();
        end_test();

        $display("summary: %0d run, %0d ok, %0d with errors, %0d check errors",
                 tests_run, tests_ok, tests_run - tests_ok, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
gdc_pixel_pkg.sv
gdc_ctrl_pkg.sv
signal_delay.sv
pixel_bank_writer.sv
pingpong_pixel_ram.sv
pixel_fetch.sv
pixel_out_ctrl.sv
gdc_out_top.sv
tb_clock_gen.sv
tb_gdc_out.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the GDC output testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module tb_gdc_out \
    -f sources.f -o tb_gdc_out > build.log 2>&1 &&
    ./obj_dir/tb_gdc_out > sim.log 2>&1 ||
    { cat build.log; echo "RESULT: build or run error"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "RESULT: no result in sim.log"; exit 1; }
echo "RESULT: PASS"
